// ==== design/lvda_pkg.sv ====
package lvda_pkg;

    // ******************************************************************
    // Bus widths.
    // ******************************************************************

    localparam int ADDR_W      = 9;
    localparam int DATA_W      = 26;
    localparam int DISC_W      = 24;
    localparam int INTR_W      = 7;
    localparam int SYNC_STAGES = 2;

    typedef logic [ADDR_W-1:0] pio_addr_t;
    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [DISC_W-1:0] disc_t;
    typedef logic [INTR_W-1:0] intr_t;

    // ******************************************************************
    // Process-I/O address map.
    // ******************************************************************

    localparam pio_addr_t ADDR_LOAD_BRD   = 9'h004;
    localparam pio_addr_t ADDR_READ_DISC  = 9'h011;
    localparam pio_addr_t ADDR_READ_INTR  = 9'h012;
    localparam pio_addr_t ADDR_RESET_INTR = 9'h014;
    localparam pio_addr_t ADDR_SET_MASK   = 9'h018;

    // A decoded command is valid for a single cycle.
    typedef enum logic [2:0] {
        OP_NONE,
        OP_LOAD_BRD,
        OP_READ_DISC,
        OP_READ_INTR,
        OP_RESET_INTR,
        OP_SET_MASK
    } io_op_t;

endpackage

// ==== design/discrete_conditioner.sv ====
module discrete_conditioner
    import lvda_pkg::*;
(
    input  logic  sim_clk,
    input  logic  reset,
    input  disc_t din_raw,
    input  intr_t intr_raw,
    output disc_t din_sync,
    output intr_t intr_sync
);

    // Stage 0 sees the raw line, the last stage feeds the logic.
    disc_t din_stage  [SYNC_STAGES];
    intr_t intr_stage [SYNC_STAGES];

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                din_stage[i]  <= '0;
                intr_stage[i] <= '0;
            end
        end else begin
            din_stage[0]  <= din_raw;
            intr_stage[0] <= intr_raw;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                din_stage[i]  <= din_stage[i-1];
                intr_stage[i] <= intr_stage[i-1];
            end
        end
    end

    assign din_sync  = din_stage[SYNC_STAGES-1];
    assign intr_sync = intr_stage[SYNC_STAGES-1];

endmodule

// ==== design/address_decode.sv ====
module address_decode
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  logic       pio_strobe,
    input  pio_addr_t  pio_addr,
    input  data_word_t pio_data,
    output io_op_t     op,
    output data_word_t op_data
);

    logic       cmd_valid;
    pio_addr_t  cmd_addr;
    data_word_t cmd_data;
    io_op_t     dec_op;

    // The command register loads on the strobe.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= pio_strobe;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (pio_strobe) begin
            cmd_addr <= pio_addr;
            cmd_data <= pio_data;
        end
    end

    always_comb begin
        unique case (cmd_addr)
            ADDR_LOAD_BRD:   dec_op = OP_LOAD_BRD;
            ADDR_READ_DISC:  dec_op = OP_READ_DISC;
            ADDR_READ_INTR:  dec_op = OP_READ_INTR;
            ADDR_RESET_INTR: dec_op = OP_RESET_INTR;
            ADDR_SET_MASK:   dec_op = OP_SET_MASK;
            default:         dec_op = OP_NONE;
        endcase
        if (!cmd_valid) begin
            dec_op = OP_NONE;
        end
    end

    // Decoded operation lasts one cycle.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            op <= OP_NONE;
        end else begin
            op <= dec_op;
        end
    end

    always_ff @(posedge sim_clk) begin
        op_data <= cmd_data;
    end

endmodule

// ==== design/buffer_register.sv ====
module buffer_register
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  io_op_t     op,
    input  data_word_t op_data,
    output data_word_t brd
);

    // Output buffer for the BRD discretes.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            brd <= '0;
        end else if (op == OP_LOAD_BRD) begin
            brd <= op_data;
        end
    end

endmodule

// ==== design/interrupt_register.sv ====
module interrupt_register
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  intr_t      intr_sync,
    input  io_op_t     op,
    input  data_word_t op_data,
    output intr_t      pending,
    output logic       intc
);

    intr_t intr_prev;
    intr_t intr_rise;
    intr_t clear_bits;
    intr_t mask;

    // ******************************************************************
    // Edge capture.
    // ******************************************************************

    assign intr_rise = intr_sync & ~intr_prev;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            intr_prev <= '0;
        end else begin
            intr_prev <= intr_sync;
        end
    end

    // ******************************************************************
    // Pending bits and mask.
    // ******************************************************************

    assign clear_bits = (op == OP_RESET_INTR) ? op_data[INTR_W-1:0] : '0;

    // A fresh edge beats a clear in the same cycle.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            pending <= '0;
            mask    <= '0;
        end else begin
            pending <= (pending & ~clear_bits) | intr_rise;
            if (op == OP_SET_MASK) begin
                mask <= op_data[INTR_W-1:0];
            end
        end
    end

    // The summary line to the computer lags pending by one cycle.
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            intc <= 1'b0;
        end else begin
            intc <= |(pending & ~mask);
        end
    end

endmodule

// ==== design/data_return.sv ====
module data_return
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  io_op_t     op,
    input  disc_t      din_sync,
    input  intr_t      pending,
    output data_word_t data_out,
    output logic       data_valid
);

    logic is_read;

    assign is_read = (op == OP_READ_DISC) || (op == OP_READ_INTR);

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= is_read;
        end
    end

    // The read-back word is zero-extended to the full data width.
    // It holds between reads.
    always_ff @(posedge sim_clk) begin
        case (op)
            OP_READ_DISC: begin
                data_out <= {{(DATA_W-DISC_W){1'b0}}, din_sync};
            end
            OP_READ_INTR: begin
                data_out <= {{(DATA_W-INTR_W){1'b0}}, pending};
            end
            default: begin
                data_out <= data_out;
            end
        endcase
    end

endmodule

// ==== design/lvda.sv ====
module lvda
    import lvda_pkg::*;
(
    input  logic       sim_clk,
    input  logic       reset,
    input  logic       pio_strobe,
    input  pio_addr_t  pio_addr,
    input  data_word_t pio_data,
    input  disc_t      din_raw,
    input  intr_t      intr_raw,
    output data_word_t brd,
    output data_word_t data_out,
    output logic       data_valid,
    output logic       intc
);

    disc_t      din_sync;
    intr_t      intr_sync;
    io_op_t     op;
    data_word_t op_data;
    intr_t      pending;

    // ******************************************************************
    // Input conditioning and command decode.
    // ******************************************************************

    discrete_conditioner u_discrete_conditioner (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .din_raw   (din_raw),
        .intr_raw  (intr_raw),
        .din_sync  (din_sync),
        .intr_sync (intr_sync)
    );

    address_decode u_address_decode (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .pio_strobe (pio_strobe),
        .pio_addr   (pio_addr),
        .pio_data   (pio_data),
        .op         (op),
        .op_data    (op_data)
    );

    // ******************************************************************
    // Output buffer, interrupts and read-back.
    // ******************************************************************

    buffer_register u_buffer_register (
        .sim_clk (sim_clk),
        .reset   (reset),
        .op      (op),
        .op_data (op_data),
        .brd     (brd)
    );

    interrupt_register u_interrupt_register (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .intr_sync (intr_sync),
        .op        (op),
        .op_data   (op_data),
        .pending   (pending),
        .intc      (intc)
    );

    data_return u_data_return (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .op         (op),
        .din_sync   (din_sync),
        .pending    (pending),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

// ==== verif/lvda_tb.sv ====
module lvda_tb
    import lvda_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_COMMANDS = 300;
    localparam int WINDOW_EVERY = 10;
    localparam int MAX_CYCLES   = 3000;

    logic       sim_clk;
    logic       reset;
    logic       pio_strobe;
    pio_addr_t  pio_addr;
    data_word_t pio_data;
    disc_t      din_raw;
    intr_t      intr_raw;
    data_word_t brd;
    data_word_t data_out;
    logic       data_valid;
    logic       intc;

    // Reference model state.
    data_word_t exp_brd;
    intr_t      exp_pending;
    intr_t      exp_mask;
    intr_t      intr_last;
    logic       cmd1_valid;
    logic       cmd2_valid;
    pio_addr_t  cmd1_addr;
    pio_addr_t  cmd2_addr;
    data_word_t cmd1_data;
    data_word_t cmd2_data;
    data_word_t exp_queue [$];

    int          value_errors = 0;
    int          valid_errors = 0;
    int          cycle_count  = 0;
    int unsigned seed;

    initial sim_clk = 1'b0;
    always #5 sim_clk = ~sim_clk;

    lvda u_dut (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .pio_strobe (pio_strobe),
        .pio_addr   (pio_addr),
        .pio_data   (pio_data),
        .din_raw    (din_raw),
        .intr_raw   (intr_raw),
        .brd        (brd),
        .data_out   (data_out),
        .data_valid (data_valid),
        .intc       (intc)
    );

    // ******************************************************************
    // Compare tasks.
    // ******************************************************************

    task automatic check_word(input string what, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("Error %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %0t: %s is %b, expected %b", $time, what, got, exp);
            value_errors++;
        end
    endtask

    // ******************************************************************
    // Reference model.
    // ******************************************************************

    task automatic apply_command(input pio_addr_t addr, input data_word_t data);
        case (addr)
            ADDR_LOAD_BRD:   exp_brd = data;
            ADDR_READ_DISC:  exp_queue.push_back(data_word_t'(din_raw));
            ADDR_READ_INTR:  exp_queue.push_back(data_word_t'(exp_pending));
            ADDR_RESET_INTR: exp_pending = exp_pending & ~data[INTR_W-1:0];
            ADDR_SET_MASK:   exp_mask = data[INTR_W-1:0];
            default:         ;
        endcase
    endtask

    // A command sampled at edge k takes effect at edge k+2.
    always @(posedge sim_clk) begin
        if (reset) begin
            exp_brd     = '0;
            exp_pending = '0;
            exp_mask    = '0;
            intr_last   = '0;
            cmd1_valid  = 1'b0;
            cmd2_valid  = 1'b0;
            exp_queue.delete();
        end else begin
            if (cmd2_valid) begin
                apply_command(cmd2_addr, cmd2_data);
            end
            exp_pending = exp_pending | (intr_raw & ~intr_last);
            intr_last   = intr_raw;
            cmd2_valid  = cmd1_valid;
            cmd2_addr   = cmd1_addr;
            cmd2_data   = cmd1_data;
            cmd1_valid  = pio_strobe;
            cmd1_addr   = pio_addr;
            cmd1_data   = pio_data;
        end
    end

    // Outputs are compared half a cycle after the edge.
    always @(negedge sim_clk) begin
        if (!reset) begin
            check_word("brd", brd, exp_brd);
            if (data_valid === 1'b1) begin
                if (exp_queue.size() == 0) begin
                    $display("Unexpected data_valid pulse with no read outstanding at %0t",
                             $time);
                    valid_errors++;
                end else begin
                    check_word("data_out", data_out, exp_queue.pop_front());
                end
            end else if (exp_queue.size() != 0) begin
                $display("Missing data_valid for a read command at %0t", $time);
                valid_errors++;
                void'(exp_queue.pop_front());
            end
        end
    end

    always @(posedge sim_clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("value errors: %0d, data_valid errors: %0d", value_errors, valid_errors);
            $display("sim failed");
            $finish;
        end
    end

    // ******************************************************************
    // Stimulus.
    // ******************************************************************

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge sim_clk);
            #1;
        end
    endtask

    task automatic send_command(input pio_addr_t addr, input data_word_t data);
        pio_strobe = 1'b1;
        pio_addr   = addr;
        pio_data   = data;
        @(posedge sim_clk);
        #1;
        pio_strobe = 1'b0;
        pio_addr   = '0;
        pio_data   = '0;
    endtask

    function automatic logic is_mapped(input pio_addr_t addr);
        return addr inside {ADDR_LOAD_BRD, ADDR_READ_DISC, ADDR_READ_INTR,
                            ADDR_RESET_INTR, ADDR_SET_MASK};
    endfunction

    // About one in ten addresses is outside the map.
    function automatic pio_addr_t pick_address();
        pio_addr_t addr;
        if ($urandom_range(9) == 0) begin
            do begin
                addr = pio_addr_t'($urandom);
            end while (is_mapped(addr));
        end else begin
            case ($urandom_range(4))
                0:       addr = ADDR_LOAD_BRD;
                1:       addr = ADDR_READ_DISC;
                2:       addr = ADDR_READ_INTR;
                3:       addr = ADDR_RESET_INTR;
                default: addr = ADDR_SET_MASK;
            endcase
        end
        return addr;
    endfunction

    // Drain the command pipe, move the raw inputs, let them settle.
    task automatic idle_window();
        wait_cycles(2);
        din_raw  = disc_t'($urandom);
        intr_raw = intr_t'($urandom);
        wait_cycles(4);
        check_bit("intc", intc, |(exp_pending & ~exp_mask));
    endtask

    initial begin
        seed = 32'ha8b8_8126;
        void'($urandom(seed));
        reset      = 1'b1;
        pio_strobe = 1'b0;
        pio_addr   = '0;
        pio_data   = '0;
        din_raw    = '0;
        intr_raw   = '0;
        repeat (2) @(posedge sim_clk);
        #1;
        reset = 1'b0;

        check_word("brd after reset", brd, '0);
        check_bit("intc after reset", intc, 1'b0);
        check_bit("data_valid after reset", data_valid, 1'b0);

        for (int i = 0; i < NUM_COMMANDS; i++) begin
            if (i % WINDOW_EVERY == 0) begin
                idle_window();
            end
            send_command(pick_address(), data_word_t'($urandom));
            wait_cycles($urandom_range(2));
        end
        idle_window();
        wait_cycles(4);

        $display("value errors: %0d, data_valid errors: %0d", value_errors, valid_errors);
        if (value_errors + valid_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
design/lvda_pkg.sv
design/discrete_conditioner.sv
design/address_decode.sv
design/buffer_register.sv
design/interrupt_register.sv
design/data_return.sv
design/lvda.sv
verif/lvda_tb.sv

// ==== Bender.yml ====
package:
  name: lvda

sources:
  # Design sources in compile order.
  - files:
      - design/lvda_pkg.sv
      - design/discrete_conditioner.sv
      - design/address_decode.sv
      - design/buffer_register.sv
      - design/interrupt_register.sv
      - design/data_return.sv
      - design/lvda.sv

  # Testbench.
  - target: simulation
    files:
      - verif/lvda_tb.sv
